// File: flist.f
hw/exec_pkg.sv
hw/forward_unit.sv
hw/alu_control.sv
hw/alu.sv
hw/exec_stage.sv
hw/writeback_pipe.sv
hw/exec_top.sv
sim/exec_props.sv
sim/exec_tb.sv

// File: Bender.yml
package:
  name: exec_pipe

sources:
  - files:
      - hw/exec_pkg.sv
      - hw/forward_unit.sv
      - hw/alu_control.sv
      - hw/alu.sv
      - hw/exec_stage.sv
      - hw/writeback_pipe.sv
      - hw/exec_top.sv
  - target: simulation
    files:
      - sim/exec_props.sv
      - sim/exec_tb.sv

// File: sim/exec_tb.sv
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int          N_INSTR      = 2000;
    localparam int          PERIOD       = 100;
    localparam int          RESET_CYCLES = 8;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          TIMEOUT      = (RESET_CYCLES + N_INSTR * 4) * PERIOD;
    localparam logic [31:0] SEED         = 32'hc18b_51af;

    logic      clk;
    logic      reset;
    logic      advance;
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     reg1_data;
    word_t     reg2_data;
    word_t     immediat;
    addr_t     old_pc;
    reg_addr_t dst_reg_in;
    logic      regwrite_in, alusrc, do_read, do_write, is_byte, memtoreg, is_branch_in;
    word_t     alu_result, data_store, wb_data;
    addr_t     pc_branch;
    reg_addr_t dst_reg, wb_dst;
    logic      zero, overflow, regwrite_out, do_read_out, do_write_out, is_byte_out;
    logic      memtoreg_out, is_branch_out, wb_valid, wb_memtoreg, wb_regwrite;

    opcode_t op_list [0:11] = '{OP_RTYPE, OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
                                OP_SLTI, OP_SLTIU, OP_LW, OP_SW, OP_BEQ, OP_BNE};
    funct_t  fn_list [0:11] = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR,
                                F_XOR, F_NOR, F_SLT, F_SLTU, F_SLL, F_SRL};

    word_t     rf  [0:31];                      // Register file seen by the DUT
    word_t     vis [0:31];                      // Program-order state, lags two instrs
    reg_addr_t rec_dst [0:N_INSTR-1];           // Per-instruction results
    logic      rec_we  [0:N_INSTR-1];
    word_t     rec_res [0:N_INSTR-1];
    logic      rec_mtr [0:N_INSTR-1];
    int        count;                           // Instructions accepted so far
    int        errors;

    word_t     exp_result, exp_store;           // Expected execute register
    addr_t     exp_pc;
    reg_addr_t exp_dst;
    logic      exp_zero, exp_ovf, exp_we, exp_rd, exp_wr, exp_byte, exp_mtr, exp_br;

    exec_top dut (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s instr %0d expected %h actual %h", name, count, exp, act);
            $display("tests failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s instr %0d expected %h actual %h", name, count, exp, act);
            $display("tests failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s instr %0d expected %0d actual %0d", name, count, exp, act);
            $display("tests failed");
            $fatal(1, "register number mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s instr %0d expected %b actual %b", name, count, exp, act);
            $display("tests failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Reference ALU straight from the instruction rules
    function automatic word_t model_alu(input opcode_t op, input funct_t fn,
                                        input word_t a, input word_t b, output logic ovf);
        logic [32:0] wide;                      // Sign-extended sum or difference
        word_t       res;
        ovf  = 1'b0;
        wide = {a[31], a} + {b[31], b};
        if ((op == OP_RTYPE && fn == F_SUB) || op == OP_BEQ || op == OP_BNE) begin
            wide = {a[31], a} - {b[31], b};
            res  = wide[31:0];
            ovf  = wide[32] ^ wide[31];         // Signed result out of range
        end else if ((op == OP_RTYPE && fn == F_ADD) || op == OP_ADDI ||
                     op == OP_LW || op == OP_SW) begin
            res = wide[31:0];
            ovf = wide[32] ^ wide[31];
        end else if (op == OP_RTYPE) begin
            case (fn)
                F_SUBU:  res = a - b;
                F_AND:   res = a & b;
                F_OR:    res = a | b;
                F_XOR:   res = a ^ b;
                F_NOR:   res = ~(a | b);
                F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
                F_SLL:   res = a << b[4:0];
                F_SRL:   res = a >> b[4:0];
                default: res = a + b;           // addu
            endcase
        end else begin
            case (op)
                OP_ANDI:  res = a & b;
                OP_ORI:   res = a | b;
                OP_XORI:  res = a ^ b;
                OP_SLTI:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_SLTIU: res = (a < b) ? 32'd1 : 32'd0;
                default:  res = a + b;          // addiu
            endcase
        end
        return res;
    endfunction

    task automatic drive_random();
        logic [15:0] imm16;
        opcode_t     op;
        op           = op_list[$urandom_range(11, 0)];
        imm16        = 16'($urandom);
        opcode       = op;
        funct        = fn_list[$urandom_range(11, 0)];
        rs_addr      = reg_addr_t'($urandom_range(7, 0)); // Small range, many hazards
        rt_addr      = reg_addr_t'($urandom_range(7, 0));
        dst_reg_in   = reg_addr_t'($urandom_range(7, 0));
        reg1_data    = rf[rs_addr];
        reg2_data    = rf[rt_addr];
        if (op == OP_ANDI || op == OP_ORI || op == OP_XORI) begin
            immediat = {16'h0000, imm16};       // Logic ops zero extend
        end else begin
            immediat = {{16{imm16[15]}}, imm16};
        end
        old_pc       = $urandom & 32'hffff_fffc;
        alusrc       = (op == OP_RTYPE) || (op == OP_BEQ) || (op == OP_BNE);
        regwrite_in  = !((op == OP_SW) || (op == OP_BEQ) || (op == OP_BNE));
        do_read      = (op == OP_LW);
        do_write     = (op == OP_SW);
        memtoreg     = (op == OP_LW);
        is_byte      = 1'($urandom_range(1, 0));
        is_branch_in = (op == OP_BEQ) || (op == OP_BNE);
        advance      = ($urandom_range(3, 0) != 0); // About 75 percent high
    endtask

    // Called after an advancing edge took the presented instruction
    task automatic accept_model();
        word_t a;
        word_t b_reg;
        word_t res;
        logic  ovf;
        int    k;
        k          = count;
        a          = vis[rs_addr];
        b_reg      = vis[rt_addr];
        res        = model_alu(opcode, funct, a, alusrc ? b_reg : immediat, ovf);
        exp_result = res;
        exp_zero   = (res == 32'd0);
        exp_ovf    = ovf;
        exp_store  = b_reg;
        exp_pc     = old_pc + {immediat[29:0], 2'b00};
        exp_dst    = dst_reg_in;
        exp_we     = regwrite_in;
        exp_rd     = do_read;
        exp_wr     = do_write;
        exp_byte   = is_byte;
        exp_mtr    = memtoreg;
        exp_br     = is_branch_in;
        rec_dst[k] = dst_reg_in;
        rec_we[k]  = regwrite_in;
        rec_res[k] = res;
        rec_mtr[k] = memtoreg;
        if (k >= 1) begin
            if (rec_we[k-1] && rec_dst[k-1] != 5'd0) begin
                vis[rec_dst[k-1]] = rec_res[k-1];   // r0 stays zero
            end
        end
        if (k >= 3) begin
            if (rec_we[k-3] && rec_dst[k-3] != 5'd0) begin
                rf[rec_dst[k-3]] = rec_res[k-3]; // Left the write-back slot
            end
        end
        count++;
    endtask

    task automatic check_outputs();
        int        w;
        logic      we;
        reg_addr_t dst;
        word_t     data;
        logic      mtr;
        w    = count - 3;                       // Index now in the write-back slot
        we   = (w >= 0) ? rec_we[w] : 1'b0;
        dst  = (w >= 0) ? rec_dst[w] : 5'd0;
        data = (w >= 0) ? rec_res[w] : 32'd0;
        mtr  = (w >= 0) ? rec_mtr[w] : 1'b0;
        check_word("exec alu_result", exp_result, alu_result);
        check_flag("exec zero", exp_zero, zero);
        check_flag("exec overflow", exp_ovf, overflow);
        check_addr("exec pc_branch", exp_pc, pc_branch);
        check_word("exec data_store", exp_store, data_store);
        check_reg("exec dst_reg", exp_dst, dst_reg);
        check_flag("exec regwrite_out", exp_we, regwrite_out);
        check_flag("exec do_read_out", exp_rd, do_read_out);
        check_flag("exec do_write_out", exp_wr, do_write_out);
        check_flag("exec is_byte_out", exp_byte, is_byte_out);
        check_flag("exec memtoreg_out", exp_mtr, memtoreg_out);
        check_flag("exec is_branch_out", exp_br, is_branch_out);
        check_flag("wb regwrite", we, wb_regwrite);
        check_flag("wb valid", we && (dst != 5'd0), wb_valid);
        check_reg("wb dst", dst, wb_dst);
        check_word("wb data", data, wb_data);
        check_flag("wb memtoreg", mtr, wb_memtoreg);
    endtask

    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        advance      = 1'b0;
        opcode       = '0;
        funct        = '0;
        rs_addr      = '0;
        rt_addr      = '0;
        reg1_data    = '0;
        reg2_data    = '0;
        immediat     = '0;
        old_pc       = '0;
        dst_reg_in   = '0;
        regwrite_in  = 1'b0;
        alusrc       = 1'b0;
        do_read      = 1'b0;
        do_write     = 1'b0;
        is_byte      = 1'b0;
        memtoreg     = 1'b0;
        is_branch_in = 1'b0;
        count        = 0;
        errors       = 0;
        {exp_result, exp_store, exp_pc, exp_dst} = '0;
        {exp_zero, exp_ovf, exp_we, exp_rd, exp_wr, exp_byte, exp_mtr, exp_br} = '0;
        for (int r = 0; r < 32; r++) begin
            rf[r]  = (r != 0 && r < 8) ? word_t'($urandom) : 32'd0; // Wide values for overflow
            vis[r] = rf[r];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        @(posedge clk);                         // One idle edge, advance low
        #(DRIVE_DELAY);
        check_outputs();
        while (count < N_INSTR) begin
            drive_random();
            @(posedge clk);
            #(DRIVE_DELAY);
            if (advance) begin
                accept_model();
            end
            check_outputs();                    // Frozen edges must match old state
        end
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the instruction stream did not complete in time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sim/exec_props.sv
`timescale 1ns/1ps

module exec_props import exec_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      advance,
    input word_t     alu_result,
    input word_t     data_store,
    input addr_t     pc_branch,
    input reg_addr_t dst_reg,
    input logic      zero,
    input logic      overflow,
    input logic      regwrite_out,
    input logic      do_read_out,
    input logic      do_write_out,
    input logic      is_branch_out
);

    // Controls cleared one edge after reset is seen
    a_reset_ctrl: assert property (@(posedge clk)
        reset |=> !regwrite_out && !do_read_out && !do_write_out && !is_branch_out)
        else $error("execute controls not cleared after reset");

    a_reset_data: assert property (@(posedge clk)
        reset |=> (alu_result == '0) && (data_store == '0) && (pc_branch == '0))
        else $error("execute data not cleared after reset");

    // Frozen pipeline keeps every output
    a_hold: assert property (@(posedge clk) disable iff (reset)
        !advance |=> $stable(alu_result) && $stable(data_store) && $stable(pc_branch) &&
                     $stable(dst_reg) && $stable(zero) && $stable(overflow) &&
                     $stable(regwrite_out) && $stable(do_read_out) &&
                     $stable(do_write_out) && $stable(is_branch_out))
        else $error("execute output changed while advance was low");

endmodule

bind exec_stage exec_props u_exec_props (
    .clk           (clk),
    .reset         (reset),
    .advance       (advance),
    .alu_result    (alu_result),
    .data_store    (data_store),
    .pc_branch     (pc_branch),
    .dst_reg       (dst_reg),
    .zero          (zero),
    .overflow      (overflow),
    .regwrite_out  (regwrite_out),
    .do_read_out   (do_read_out),
    .do_write_out  (do_write_out),
    .is_branch_out (is_branch_out)
);

// File: hw/exec_top.sv
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      advance,                  // Global pipeline enable
    input  opcode_t   opcode,
    input  funct_t    funct,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  word_t     reg1_data,
    input  word_t     reg2_data,
    input  word_t     immediat,
    input  addr_t     old_pc,
    input  reg_addr_t dst_reg_in,
    input  logic      regwrite_in,
    input  logic      alusrc,
    input  logic      do_read,
    input  logic      do_write,
    input  logic      is_byte,
    input  logic      memtoreg,
    input  logic      is_branch_in,
    output word_t     alu_result,
    output logic      zero,
    output logic      overflow,
    output addr_t     pc_branch,
    output word_t     data_store,
    output reg_addr_t dst_reg,
    output logic      regwrite_out,
    output logic      do_read_out,
    output logic      do_write_out,
    output logic      is_byte_out,
    output logic      memtoreg_out,
    output logic      is_branch_out,
    output logic      wb_valid,                 // Write-back port
    output reg_addr_t wb_dst,
    output word_t     wb_data,
    output logic      wb_memtoreg,
    output logic      wb_regwrite
);

    fwd_sel_t  forward_src1;
    fwd_sel_t  forward_src2;
    word_t     mem_forward;
    word_t     wb_forward;
    reg_addr_t mem_dst;
    logic      mem_regwrite;

    forward_unit u_forward_unit (
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .mem_dst      (mem_dst),
        .wb_dst       (wb_dst),
        .mem_regwrite (mem_regwrite),
        .wb_regwrite  (wb_regwrite),
        .forward_src1 (forward_src1),
        .forward_src2 (forward_src2)
    );

    exec_stage u_exec_stage (
        .clk           (clk),
        .reset         (reset),
        .advance       (advance),
        .opcode        (opcode),
        .funct         (funct),
        .reg1_data     (reg1_data),
        .reg2_data     (reg2_data),
        .immediat      (immediat),
        .mem_forward   (mem_forward),
        .wb_forward    (wb_forward),
        .old_pc        (old_pc),
        .dst_reg_in    (dst_reg_in),
        .forward_src1  (forward_src1),
        .forward_src2  (forward_src2),
        .alusrc        (alusrc),
        .regwrite_in   (regwrite_in),
        .do_read       (do_read),
        .do_write      (do_write),
        .is_byte       (is_byte),
        .memtoreg      (memtoreg),
        .is_branch_in  (is_branch_in),
        .alu_result    (alu_result),
        .data_store    (data_store),
        .pc_branch     (pc_branch),
        .dst_reg       (dst_reg),
        .zero          (zero),
        .overflow      (overflow),
        .regwrite_out  (regwrite_out),
        .do_read_out   (do_read_out),
        .do_write_out  (do_write_out),
        .is_byte_out   (is_byte_out),
        .memtoreg_out  (memtoreg_out),
        .is_branch_out (is_branch_out)
    );

    writeback_pipe u_writeback_pipe (
        .clk          (clk),
        .reset        (reset),
        .advance      (advance),
        .alu_result   (alu_result),
        .dst_reg      (dst_reg),
        .regwrite_out (regwrite_out),
        .memtoreg_out (memtoreg_out),
        .mem_forward  (mem_forward),
        .wb_forward   (wb_forward),
        .mem_dst      (mem_dst),
        .wb_dst       (wb_dst),
        .mem_regwrite (mem_regwrite),
        .wb_regwrite  (wb_regwrite),
        .wb_valid     (wb_valid),
        .wb_memtoreg  (wb_memtoreg),
        .wb_data      (wb_data)
    );

endmodule

// File: hw/writeback_pipe.sv
`timescale 1ns/1ps

module writeback_pipe import exec_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      advance,
    input  word_t     alu_result,               // From execute register
    input  reg_addr_t dst_reg,
    input  logic      regwrite_out,
    input  logic      memtoreg_out,
    output word_t     mem_forward,              // Memory slot value
    output word_t     wb_forward,               // Write-back slot value
    output reg_addr_t mem_dst,
    output reg_addr_t wb_dst,
    output logic      mem_regwrite,
    output logic      wb_regwrite,
    output logic      wb_valid,                 // Register file write strobe
    output logic      wb_memtoreg,
    output word_t     wb_data
);

    logic mem_memtoreg;                         // Carried to write-back slot

    // Two-slot shift register, moves only on advance
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_forward  <= '0;
            mem_dst      <= '0;
            mem_regwrite <= 1'b0;
            mem_memtoreg <= 1'b0;
            wb_forward   <= '0;
            wb_dst       <= '0;
            wb_regwrite  <= 1'b0;
            wb_memtoreg  <= 1'b0;
        end else if (advance) begin
            mem_forward  <= alu_result;         // Loads still pass ALU result
            mem_dst      <= dst_reg;
            mem_regwrite <= regwrite_out;
            mem_memtoreg <= memtoreg_out;
            wb_forward   <= mem_forward;
            wb_dst       <= mem_dst;
            wb_regwrite  <= mem_regwrite;
            wb_memtoreg  <= mem_memtoreg;
        end
    end

    // Writes to r0 are dropped
    assign wb_valid = wb_regwrite && (wb_dst != '0);
    assign wb_data  = wb_forward;

endmodule

// File: hw/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      advance,                  // Pipeline enable, freezes all when low
    input  opcode_t   opcode,
    input  funct_t    funct,
    input  word_t     reg1_data,                // rs value from register file
    input  word_t     reg2_data,                // rt value from register file
    input  word_t     immediat,                 // Already extended by decode
    input  word_t     mem_forward,              // Memory slot result
    input  word_t     wb_forward,               // Write-back slot result
    input  addr_t     old_pc,
    input  reg_addr_t dst_reg_in,
    input  fwd_sel_t  forward_src1,
    input  fwd_sel_t  forward_src2,
    input  logic      alusrc,                   // 1 takes rt, 0 takes immediate
    input  logic      regwrite_in,
    input  logic      do_read,
    input  logic      do_write,
    input  logic      is_byte,
    input  logic      memtoreg,
    input  logic      is_branch_in,
    output word_t     alu_result,
    output word_t     data_store,               // Store data for sw
    output addr_t     pc_branch,
    output reg_addr_t dst_reg,
    output logic      zero,
    output logic      overflow,
    output logic      regwrite_out,
    output logic      do_read_out,
    output logic      do_write_out,
    output logic      is_byte_out,
    output logic      memtoreg_out,
    output logic      is_branch_out
);

    alu_op_t alu_op;
    word_t   operand1;
    word_t   reg2_fwd;                          // rt after forwarding
    word_t   operand2;
    word_t   alu_res_c;
    logic    alu_zero_c;
    logic    alu_ovf_c;
    addr_t   branch_target;

    // Each operand has its own select
    always_comb begin
        case (forward_src1)
            FWD_MEM: operand1 = mem_forward;
            FWD_WB:  operand1 = wb_forward;
            default: operand1 = reg1_data;
        endcase
        case (forward_src2)
            FWD_MEM: reg2_fwd = mem_forward;
            FWD_WB:  reg2_fwd = wb_forward;
            default: reg2_fwd = reg2_data;
        endcase
    end

    assign operand2      = alusrc ? reg2_fwd : immediat;
    assign branch_target = old_pc + addr_t'(immediat << 2); // Word offset to bytes

    alu_control u_alu_control (
        .opcode (opcode),
        .funct  (funct),
        .alu_op (alu_op)
    );

    alu u_alu (
        .alu_op   (alu_op),
        .src1     (operand1),
        .src2     (operand2),
        .result   (alu_res_c),
        .zero     (alu_zero_c),
        .overflow (alu_ovf_c)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_result    <= '0;
            zero          <= 1'b0;
            overflow      <= 1'b0;
            data_store    <= '0;
            pc_branch     <= '0;
            dst_reg       <= '0;
            regwrite_out  <= 1'b0;
            do_read_out   <= 1'b0;
            do_write_out  <= 1'b0;
            is_byte_out   <= 1'b0;
            memtoreg_out  <= 1'b0;
            is_branch_out <= 1'b0;
        end else if (advance) begin
            alu_result    <= alu_res_c;
            zero          <= alu_zero_c;
            overflow      <= alu_ovf_c;
            data_store    <= reg2_fwd;          // Forwarded rt, never the immediate
            pc_branch     <= branch_target;
            dst_reg       <= dst_reg_in;
            regwrite_out  <= regwrite_in;
            do_read_out   <= do_read;
            do_write_out  <= do_write;
            is_byte_out   <= is_byte;
            memtoreg_out  <= memtoreg;
            is_branch_out <= is_branch_in;
        end
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result,
    output logic    zero,                       // Result is all zeros
    output logic    overflow                    // Signed overflow, add/sub only
);

    word_t                sum;                  // Shared adder output
    word_t                diff;                 // Shared subtractor output
    logic [SHAMT_W-1:0]   shamt;
    logic                 lt_signed;
    logic                 lt_unsigned;
    logic                 add_ovf;
    logic                 sub_ovf;

    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign shamt       = src2[SHAMT_W-1:0];     // Low five bits only
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    // Same-sign inputs, result sign flips
    assign add_ovf = (src1[WORD_W-1] == src2[WORD_W-1]) &&
                     (sum[WORD_W-1] != src1[WORD_W-1]);
    // Opposite-sign inputs, result takes src2 sign
    assign sub_ovf = (src1[WORD_W-1] != src2[WORD_W-1]) &&
                     (diff[WORD_W-1] != src1[WORD_W-1]);

    always_comb begin
        case (alu_op)
            ALU_ADD,
            ALU_ADDU: result = sum;
            ALU_SUB,
            ALU_SUBU: result = diff;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLT:  result = word_t'(lt_signed);  // Zero-extended flag
            ALU_SLTU: result = word_t'(lt_unsigned);
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;   // Logical, zero fill
            default:  result = sum;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD: overflow = add_ovf;
            ALU_SUB: overflow = sub_ovf;
            default: overflow = 1'b0;           // Unsigned and logic ops never flag
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: hw/alu_control.sv
`timescale 1ns/1ps

module alu_control import exec_pkg::*; (
    input  opcode_t opcode,
    input  funct_t  funct,                      // Only meaningful for R-type
    output alu_op_t alu_op
);

    alu_op_t r_op;                              // Decode of funct field
    alu_op_t i_op;                              // Decode of opcode

    always_comb begin
        case (funct)
            F_ADD:   r_op = ALU_ADD;
            F_ADDU:  r_op = ALU_ADDU;
            F_SUB:   r_op = ALU_SUB;
            F_SUBU:  r_op = ALU_SUBU;
            F_AND:   r_op = ALU_AND;
            F_OR:    r_op = ALU_OR;
            F_XOR:   r_op = ALU_XOR;
            F_NOR:   r_op = ALU_NOR;
            F_SLT:   r_op = ALU_SLT;
            F_SLTU:  r_op = ALU_SLTU;
            F_SLL:   r_op = ALU_SLL;
            F_SRL:   r_op = ALU_SRL;
            default: r_op = ALU_ADDU;           // Unknown funct, harmless add
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ADDI,
            OP_LW,
            OP_SW:    i_op = ALU_ADD;           // Address calc uses signed add
            OP_ADDIU: i_op = ALU_ADDU;
            OP_ANDI:  i_op = ALU_AND;
            OP_ORI:   i_op = ALU_OR;
            OP_XORI:  i_op = ALU_XOR;
            OP_SLTI:  i_op = ALU_SLT;
            OP_SLTIU: i_op = ALU_SLTU;
            OP_BEQ,
            OP_BNE:   i_op = ALU_SUB;           // Compare via zero flag
            default:  i_op = ALU_ADDU;
        endcase
    end

    assign alu_op = (opcode == OP_RTYPE) ? r_op : i_op;

endmodule

// File: hw/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import exec_pkg::*; (
    input  reg_addr_t rs_addr,                  // First source of instr in decode
    input  reg_addr_t rt_addr,                  // Second source
    input  reg_addr_t mem_dst,                  // Destination in memory slot
    input  reg_addr_t wb_dst,                   // Destination in write-back slot
    input  logic      mem_regwrite,
    input  logic      wb_regwrite,
    output fwd_sel_t  forward_src1,
    output fwd_sel_t  forward_src2
);

    // Same priority rule for both operands
    function automatic fwd_sel_t pick_src(
        input reg_addr_t src,
        input reg_addr_t m_dst,
        input logic      m_we,
        input reg_addr_t w_dst,
        input logic      w_we
    );
        logic     mem_hit;
        logic     wb_hit;
        fwd_sel_t sel;
        mem_hit = m_we && (m_dst != '0) && (m_dst == src); // r0 never forwarded
        wb_hit  = w_we && (w_dst != '0) && (w_dst == src);
        if (mem_hit) begin
            sel = FWD_MEM;                      // Youngest producer wins
        end else if (wb_hit) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        forward_src1 = pick_src(rs_addr, mem_dst, mem_regwrite, wb_dst, wb_regwrite);
        forward_src2 = pick_src(rt_addr, mem_dst, mem_regwrite, wb_dst, wb_regwrite);
    end

endmodule

// File: hw/exec_pkg.sv
package exec_pkg;

    localparam int WORD_W     = 32;             // Data and PC width
    localparam int REG_ADDR_W = 5;              // 32 architectural registers
    localparam int FIELD_W    = 6;              // Opcode and funct field width
    localparam int SHAMT_W    = 5;              // Shift amount bits taken from src2

    typedef logic [WORD_W-1:0]     word_t;      // Register data, immediate, result
    typedef logic [WORD_W-1:0]     addr_t;      // Program counter
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register number
    typedef logic [FIELD_W-1:0]    opcode_t;    // Instruction [31:26]
    typedef logic [FIELD_W-1:0]    funct_t;     // Instruction [5:0], R-type only

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,                        // Signed add, traps on overflow
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,                        // Signed sub, traps on overflow
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,                         // Value from register read
        FWD_WB  = 2'd1,                         // Value from write-back slot
        FWD_MEM = 2'd2                          // Value from memory slot
    } fwd_sel_t;

    localparam opcode_t OP_RTYPE = 6'h00;       // Selects by funct
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t F_SLL  = 6'h00;
    localparam funct_t F_SRL  = 6'h02;
    localparam funct_t F_ADD  = 6'h20;
    localparam funct_t F_ADDU = 6'h21;
    localparam funct_t F_SUB  = 6'h22;
    localparam funct_t F_SUBU = 6'h23;
    localparam funct_t F_AND  = 6'h24;
    localparam funct_t F_OR   = 6'h25;
    localparam funct_t F_XOR  = 6'h26;
    localparam funct_t F_NOR  = 6'h27;
    localparam funct_t F_SLT  = 6'h2a;
    localparam funct_t F_SLTU = 6'h2b;

endpackage
